// File: bench/packet_switch_tb.sv
`timescale 1ns/1ps

module packet_switch_tb;

  // Cycles a single wait may last
  localparam int TIMEOUT = 2000;

  logic               clock;
  logic               reset;
  logic               s_valid_i;
  pkt_pkg::in_beat_t  s_beat_i;
  logic               drop_i;
  logic               s_ready_o;
  logic               m_valid_o;
  pkt_pkg::out_beat_t m_beat_o;
  logic               m_ready_i;
  logic               ack_i;
  logic               nack_i;

  int    seed;
  logic  stall_seen;
  // Test names that expected entries point into
  string names[$];
  // Expected words per lane as {name index, last, data}
  int    exp_q[pkt_pkg::LANES][$];
  // Nacks still to give and commit time per lane and committed frame
  int    nack_q[pkt_pkg::LANES][$];
  int    commit_q[pkt_pkg::LANES][$];

  packet_switch packet_switch_i (
    .clock     (clock),
    .reset     (reset),
    .s_valid_i (s_valid_i),
    .s_beat_i  (s_beat_i),
    .drop_i    (drop_i),
    .s_ready_o (s_ready_o),
    .m_valid_o (m_valid_o),
    .m_beat_o  (m_beat_o),
    .m_ready_i (m_ready_i),
    .ack_i     (ack_i),
    .nack_i    (nack_i)
  );

  always #4 clock = !clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      abort_run("Value mismatch, run stopped");
    end
  endtask

  function automatic int pending_beats();
    int total;
    total = 0;
    for (int k = 0; k < pkt_pkg::LANES; k++) begin
      total += exp_q[k].size();
    end
    return total;
  endfunction

  // Present one beat and return at the edge that takes it
  task automatic drive_beat(input pkt_pkg::in_beat_t beat, input logic drop);
    int waited;
    waited = 0;
    s_valid_i = 1'b1;
    s_beat_i  = beat;
    drop_i    = drop;
    @(negedge clock);
    while (!s_ready_o) begin
      // Lane FIFO full so the input is held off
      stall_seen = 1'b1;
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("Timeout: s_ready_o stayed low for an input beat");
      end
      @(negedge clock);
    end
    @(posedge clock);
  endtask

  task automatic run_input();
    int                fd;
    int                n;
    int                lane;
    int                keep;
    int                last;
    int                drop;
    int                data;
    int                count;
    int                frame_lane;
    int                pending_nacks;
    int                stage[$];
    logic              first;
    string             line;
    string             kind;
    string             name;
    pkt_pkg::in_beat_t beat;
    fd = $fopen("bench/packet_switch_tests.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open bench/packet_switch_tests.txt");
    end
    pending_nacks = 0;
    frame_lane    = 0;
    first         = 1'b1;
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%s %s %d %d %d %d %h %d",
                  kind, name, lane, keep, last, drop, data, count);
      if (n == 8 && (names.size() == 0 || names[names.size() - 1] != name)) begin
        names.push_back(name);
      end
      if (n == 8 && kind == "NACK") begin
        pending_nacks = count;
      end else if (n == 8) begin
        for (int i = 0; i < count; i++) begin
          beat.lane = pkt_pkg::lane_t'(lane);
          beat.keep = keep[0];
          beat.last = last[0] && (i == count - 1);
          beat.data = pkt_pkg::data_t'(data + i);
          // Frame stays on the lane named by its first beat
          if (first) begin
            frame_lane = lane;
          end
          first = 1'b0;
          drive_beat(beat, drop[0] && beat.last);
          if (beat.keep) begin
            stage.push_back((data + i) & 'hff);
          end
          if (beat.last) begin
            // Final kept beat of a committed frame carries last
            if (!drop[0] && stage.size() > 0) begin
              foreach (stage[j]) begin
                exp_q[frame_lane].push_back(((names.size() - 1) << 9) |
                                            (int'(j == stage.size() - 1) << 8) | stage[j]);
              end
              nack_q[frame_lane].push_back(pending_nacks);
              commit_q[frame_lane].push_back(int'($time));
            end
            stage.delete();
            pending_nacks = 0;
            first         = 1'b1;
          end
          #1;
        end
      end
    end
    $fclose(fd);
    s_valid_i = 1'b0;
    drop_i    = 1'b0;
  endtask

  task automatic check_output();
    int    lane;
    int    idx;
    int    expv;
    int    delay;
    int    expect_lane;
    int    rr_base;
    int    rr_limit;
    logic  pkt_done;
    string name;
    lane        = 0;
    idx         = 0;
    expect_lane = -1;
    rr_base     = 0;
    rr_limit    = 3;
    pkt_done    = 1'b0;
    name        = "";
    forever begin
      @(negedge clock);
      if (m_valid_o && m_ready_i) begin
        if (idx == 0) begin
          lane = int'(m_beat_o.lane);
          if (exp_q[lane].size() == 0) begin
            abort_run("Packet came out on a lane with nothing committed");
          end
          if (expect_lane >= 0) begin
            // Nacked packet goes out again before any other
            check_value(names[exp_q[expect_lane][0] >> 9], expect_lane, lane);
          end else if (((lane - rr_base) & 3) > rr_limit) begin
            abort_run("Packet skipped a ready lane in round-robin order");
          end
        end
        if (idx >= exp_q[lane].size()) begin
          abort_run("More beats came out than were committed on the lane");
        end
        expv = exp_q[lane][idx];
        name = names[expv >> 9];
        // No other lane inside a packet
        check_value(name, lane, int'(m_beat_o.lane));
        check_value(name, expv & 'h1ff, int'({m_beat_o.last, m_beat_o.data}));
        idx++;
        pkt_done = m_beat_o.last;
      end
      @(posedge clock);
      #1;
      m_ready_i = ($random(seed) & 3) != 0;
      if (pkt_done) begin
        pkt_done = 1'b0;
        delay    = $random(seed) & 3;
        for (int d = 0; d <= delay; d++) begin
          if (d == delay && nack_q[lane][0] > 0) begin
            nack_i             = 1'b1;
            nack_q[lane][0]    = nack_q[lane][0] - 1;
            expect_lane        = lane;
          end else if (d == delay) begin
            ack_i = 1'b1;
            repeat (idx) void'(exp_q[lane].pop_front());
            void'(nack_q[lane].pop_front());
            void'(commit_q[lane].pop_front());
            expect_lane = -1;
            rr_base     = (lane + 1) & 3;
            rr_limit    = 3;
            // Nearest lane whose frame surely reached the merge before its next pick
            for (int k = 3; k >= 0; k--) begin
              if (commit_q[(rr_base + k) & 3].size() > 0 &&
                  commit_q[(rr_base + k) & 3][0] <= int'($time) - 17) begin
                rr_limit = k;
              end
            end
          end
          @(negedge clock);
          // Output idle until the link answers
          check_value(name, 0, int'(m_valid_o));
          @(posedge clock);
          #1;
        end
        ack_i  = 1'b0;
        nack_i = 1'b0;
        idx    = 0;
      end
    end
  endtask

  initial begin
    int waited;
    seed       = 32'h761d_f962;
    clock      = 1'b0;
    reset      = 1'b1;
    s_valid_i  = 1'b0;
    s_beat_i   = '0;
    drop_i     = 1'b0;
    m_ready_i  = 1'b0;
    ack_i      = 1'b0;
    nack_i     = 1'b0;
    stall_seen = 1'b0;
    repeat (8) @(posedge clock);
    #1;
    check_value("reset", 0, int'({s_ready_o, m_valid_o}));
    reset = 1'b0;
    @(posedge clock);
    #1;
    // Input side opens one cycle after reset
    check_value("reset", 1, int'(s_ready_o));
    @(posedge clock);
    #1;
    fork
      check_output();
    join_none
    run_input();
    waited = 0;
    while (pending_beats() != 0) begin
      @(posedge clock);
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("Timeout: committed packets did not all come out");
      end
    end
    // Room for a stray extra packet to show up
    repeat (20) @(posedge clock);
    if (!stall_seen) begin
      abort_run("s_ready_o never went low while a lane FIFO was full");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// File: bench/packet_switch_tests.txt
# kind name lane keep last drop data(hex) count
# BEAT sends count beats, data counting up, last only on the final one; NACK count is for the next frame
BEAT basic 0 1 1 0 10 4
BEAT basic 1 1 1 0 20 3
BEAT basic 2 1 1 0 30 5
BEAT basic 3 1 1 0 40 2
BEAT keep 1 1 0 0 50 2
BEAT keep 1 0 0 0 52 1
BEAT keep 1 1 0 0 53 2
BEAT keep 1 0 1 0 55 1
BEAT drop 2 1 0 0 60 3
BEAT drop 2 1 1 1 63 1
BEAT drop 2 1 1 0 70 4
BEAT lock 0 1 0 0 80 2
BEAT lock 3 1 1 0 82 2
NACK nack 0 0 0 0 0 2
BEAT nack 1 1 1 0 90 3
NACK nack 0 0 0 0 0 1
BEAT nack 3 1 1 0 a0 6
BEAT mixed 0 1 0 0 b0 1
BEAT mixed 0 0 0 0 b1 1
BEAT mixed 0 1 1 0 b2 1
BEAT empty 2 0 1 1 c0 1
BEAT fill 3 1 1 0 00 32
BEAT fill 3 1 1 0 e0 4
NACK fill 0 0 0 0 0 1
BEAT fill 0 1 1 0 f0 3

// File: build.f
rtl/pkt_pkg.sv
rtl/packet_fifo.sv
rtl/lane_steer.sv
rtl/lane_merge.sv
rtl/packet_switch.sv
bench/packet_switch_tb.sv

// File: rtl/lane_merge.sv
`timescale 1ns/1ps

module lane_merge (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                ack_i,
  input  logic                                nack_i,

  // From the lane FIFOs
  input  logic [pkt_pkg::LANES-1:0]           lane_valid_i,
  input  pkt_pkg::word_t [pkt_pkg::LANES-1:0] lane_word_i,
  output logic [pkt_pkg::LANES-1:0]           lane_ready_o,
  output logic [pkt_pkg::LANES-1:0]           lane_next_o,
  output logic [pkt_pkg::LANES-1:0]           lane_redo_o,

  // Output stream
  output logic                                m_valid_o,
  output pkt_pkg::out_beat_t                  m_beat_o,
  input  logic                                m_ready_i
);

  pkt_pkg::merge_state_t state_q;
  pkt_pkg::lane_t        lane_q;
  pkt_pkg::lane_t        rr_q;
  pkt_pkg::lane_t        pick_lane;
  logic                  pick_found;
  logic                  sending;
  logic                  waiting;
  logic                  beat_done;

  // Round-robin search starting at rr_q
  always_comb begin
    pkt_pkg::lane_t cand;
    pick_found = 1'b0;
    pick_lane  = rr_q;
    for (int i = 0; i < pkt_pkg::LANES; i++) begin
      cand = rr_q + pkt_pkg::lane_t'(i);
      if (!pick_found && lane_valid_i[cand]) begin
        pick_found = 1'b1;
        pick_lane  = cand;
      end
    end
  end

  assign sending = state_q == pkt_pkg::SEND;
  assign waiting = state_q == pkt_pkg::WAIT_ACK;

  // Straight pass-through of the served lane
  assign m_valid_o     = sending && lane_valid_i[lane_q];
  assign m_beat_o.lane = lane_q;
  assign m_beat_o.last = lane_word_i[lane_q].last;
  assign m_beat_o.data = lane_word_i[lane_q].data;

  assign beat_done = m_valid_o && m_ready_i && m_beat_o.last;

  always_comb begin
    lane_ready_o = '0;
    lane_next_o  = '0;
    lane_redo_o  = '0;
    if (sending) begin
      lane_ready_o[lane_q] = m_ready_i;
    end
    // nack has priority over ack
    if (waiting && nack_i) begin
      lane_redo_o[lane_q] = 1'b1;
    end else if (waiting && ack_i) begin
      lane_next_o[lane_q] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= pkt_pkg::IDLE;
      lane_q  <= '0;
      rr_q    <= '0;
    end else begin
      case (state_q)
        pkt_pkg::IDLE: begin
          if (pick_found) begin
            lane_q  <= pick_lane;
            state_q <= pkt_pkg::SEND;
          end
        end
        pkt_pkg::SEND: begin
          if (beat_done) begin
            state_q <= pkt_pkg::WAIT_ACK;
          end
        end
        pkt_pkg::WAIT_ACK: begin
          if (nack_i) begin
            state_q <= pkt_pkg::REWIND;
          end else if (ack_i) begin
            // Next search starts just after the lane that was served
            rr_q    <= lane_q + 1'b1;
            state_q <= pkt_pkg::IDLE;
          end
        end
        // Lane reloads its read pointer, then the same packet again
        pkt_pkg::REWIND: state_q <= pkt_pkg::SEND;
        default:         state_q <= pkt_pkg::IDLE;
      endcase
    end
  end

endmodule

// File: rtl/lane_steer.sv
`timescale 1ns/1ps

module lane_steer (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  s_valid_i,
  input  pkt_pkg::in_beat_t                     s_beat_i,
  input  logic                                  drop_i,
  output logic                                  s_ready_o,

  // Towards the lane FIFOs
  output logic [pkt_pkg::LANES-1:0]             lane_valid_o,
  output pkt_pkg::word_t [pkt_pkg::LANES-1:0]   lane_word_o,
  output logic [pkt_pkg::LANES-1:0]             lane_keep_o,
  output logic [pkt_pkg::LANES-1:0]             lane_drop_o,
  input  logic [pkt_pkg::LANES-1:0]             lane_ready_i
);

  // Mid-frame flag and the lane locked at the frame's first beat
  logic           in_frame_q;
  pkt_pkg::lane_t lane_q;
  pkt_pkg::lane_t cur_lane;
  logic           accept;

  // First beat picks the lane, later beats follow the lock
  assign cur_lane  = in_frame_q ? lane_q : s_beat_i.lane;
  assign s_ready_o = lane_ready_i[cur_lane];
  assign accept    = s_valid_i && s_ready_o;

  always_comb begin
    for (int k = 0; k < pkt_pkg::LANES; k++) begin
      // Payload goes to every lane, valid and drop only to the selected one
      lane_valid_o[k]     = s_valid_i && (cur_lane == pkt_pkg::lane_t'(k));
      lane_drop_o[k]      = drop_i && (cur_lane == pkt_pkg::lane_t'(k));
      lane_keep_o[k]      = s_beat_i.keep;
      lane_word_o[k].last = s_beat_i.last;
      lane_word_o[k].data = s_beat_i.data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      in_frame_q <= 1'b0;
      lane_q     <= '0;
    end else if (accept) begin
      // Last beat unlocks, anything else holds the lane
      in_frame_q <= !s_beat_i.last;
      lane_q     <= cur_lane;
    end
  end

endmodule

// File: rtl/packet_fifo.sv
`timescale 1ns/1ps

module packet_fifo (
  input  logic           clock,
  input  logic           reset,

  // Write side, from the steer
  input  logic           wr_valid_i,
  input  pkt_pkg::word_t wr_word_i,
  input  logic           wr_keep_i,
  input  logic           wr_drop_i,
  output logic           wr_ready_o,

  // Read side, towards the merge
  output logic           rd_valid_o,
  output pkt_pkg::word_t rd_word_o,
  input  logic           rd_ready_i,
  input  logic           next_i,
  input  logic           redo_i
);

  // Storage, last flags held apart from the payload
  // A frame ending on a keep-low beat needs its last flag set after the fact
  pkt_pkg::data_t data_mem [pkt_pkg::DEPTH];
  logic           last_mem [pkt_pkg::DEPTH];

  // Write pointer and commit pointer (end of the last good frame)
  pkt_pkg::ptr_t wr_ptr;
  pkt_pkg::ptr_t commit_ptr;
  pkt_pkg::ptr_t wr_ptr_nxt;
  pkt_pkg::ptr_t wr_ptr_prev;
  pkt_pkg::ptr_t wr_used_nxt;

  // Read pointer, replay pointer (start of the unacked packet)
  // and end pointer (just past the packet that went out)
  pkt_pkg::ptr_t rd_ptr;
  pkt_pkg::ptr_t rd_ptr_nxt;
  pkt_pkg::ptr_t replay_ptr;
  pkt_pkg::ptr_t end_ptr;

  logic wr_ready_q;
  logic accept;
  logic frame_end;
  logic frame_drop;
  logic store;
  logic patch_last;

  logic avail_q;
  logic fetch;
  logic drain;

  // Output register, with the address just past the beat it holds
  logic           out_valid_q;
  pkt_pkg::word_t out_word_q;
  pkt_pkg::ptr_t  out_ptr;

  assign wr_ready_o = wr_ready_q;
  assign rd_valid_o = out_valid_q;
  assign rd_word_o  = out_word_q;

  // Every handshaked beat is accepted, only kept beats get stored
  assign accept     = wr_valid_i && wr_ready_q;
  assign frame_end  = accept && wr_word_i.last;
  assign frame_drop = frame_end && wr_drop_i;
  assign store      = accept && wr_keep_i && !frame_drop;

  // Last beat with keep low, mark the previous stored beat as last instead
  // Empty frames have nothing to mark
  assign patch_last = frame_end && !wr_drop_i && !wr_keep_i && (wr_ptr != commit_ptr);

  assign wr_ptr_nxt  = store ? wr_ptr + 1'b1 : wr_ptr;
  assign wr_ptr_prev = wr_ptr - 1'b1;

  // Occupancy after this cycle, counted from the replay pointer
  // since unacked beats must stay until released
  assign wr_used_nxt = wr_ptr_nxt - replay_ptr;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
      wr_ready_q <= 1'b0;
    end else begin
      // Registered ready, low once the FIFO is full
      wr_ready_q <= wr_used_nxt != pkt_pkg::ptr_t'(pkt_pkg::DEPTH);
      if (frame_drop) begin
        // CRC failure, forget the whole frame
        wr_ptr <= commit_ptr;
      end else begin
        wr_ptr <= wr_ptr_nxt;
        // Frame becomes visible to the reader
        if (frame_end) begin
          commit_ptr <= wr_ptr_nxt;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (store) begin
      data_mem[wr_ptr[pkt_pkg::ADDR_BITS-1:0]] <= wr_word_i.data;
      last_mem[wr_ptr[pkt_pkg::ADDR_BITS-1:0]] <= wr_word_i.last;
    end else if (patch_last) begin
      last_mem[wr_ptr_prev[pkt_pkg::ADDR_BITS-1:0]] <= 1'b1;
    end
  end

  // Fetch into the output register when it is empty or being emptied
  // No fetch in the redo cycle, the read pointer is being reloaded
  assign drain = out_valid_q && rd_ready_i;
  assign fetch = avail_q && (!out_valid_q || rd_ready_i) && !redo_i;

  assign rd_ptr_nxt = redo_i ? replay_ptr : (fetch ? rd_ptr + 1'b1 : rd_ptr);

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr      <= '0;
      replay_ptr  <= '0;
      end_ptr     <= '0;
      avail_q     <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      rd_ptr <= rd_ptr_nxt;
      // Committed data waiting behind the read pointer
      avail_q <= rd_ptr_nxt != commit_ptr;

      if (redo_i) begin
        out_valid_q <= 1'b0;
      end else if (fetch) begin
        out_valid_q <= 1'b1;
      end else if (drain) begin
        out_valid_q <= 1'b0;
      end

      // Remember where the packet ended as its last beat leaves
      if (drain && out_word_q.last) begin
        end_ptr <= out_ptr;
      end

      // Packet acked, release its space
      if (next_i) begin
        replay_ptr <= end_ptr;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fetch) begin
      out_word_q.last <= last_mem[rd_ptr[pkt_pkg::ADDR_BITS-1:0]];
      out_word_q.data <= data_mem[rd_ptr[pkt_pkg::ADDR_BITS-1:0]];
      out_ptr         <= rd_ptr + 1'b1;
    end
  end

endmodule

// File: rtl/packet_switch.sv
`timescale 1ns/1ps

module packet_switch (
  input  logic               clock,
  input  logic               reset,
  input  logic               s_valid_i,
  input  pkt_pkg::in_beat_t  s_beat_i,
  input  logic               drop_i,
  output logic               s_ready_o,
  output logic               m_valid_o,
  output pkt_pkg::out_beat_t m_beat_o,
  input  logic               m_ready_i,
  input  logic               ack_i,
  input  logic               nack_i
);

  // Steer to FIFO write sides
  logic [pkt_pkg::LANES-1:0]           wr_valid;
  pkt_pkg::word_t [pkt_pkg::LANES-1:0] wr_word;
  logic [pkt_pkg::LANES-1:0]           wr_keep;
  logic [pkt_pkg::LANES-1:0]           wr_drop;
  logic [pkt_pkg::LANES-1:0]           wr_ready;

  // FIFO read sides to merge
  logic [pkt_pkg::LANES-1:0]           rd_valid;
  pkt_pkg::word_t [pkt_pkg::LANES-1:0] rd_word;
  logic [pkt_pkg::LANES-1:0]           rd_ready;
  logic [pkt_pkg::LANES-1:0]           rd_next;
  logic [pkt_pkg::LANES-1:0]           rd_redo;

  lane_steer steer_i (
    .clock        (clock),
    .reset        (reset),
    .s_valid_i    (s_valid_i),
    .s_beat_i     (s_beat_i),
    .drop_i       (drop_i),
    .s_ready_o    (s_ready_o),
    .lane_valid_o (wr_valid),
    .lane_word_o  (wr_word),
    .lane_keep_o  (wr_keep),
    .lane_drop_o  (wr_drop),
    .lane_ready_i (wr_ready)
  );

  // One packet FIFO per lane
  for (genvar k = 0; k < pkt_pkg::LANES; k++) begin : g_lane
    packet_fifo fifo_i (
      .clock      (clock),
      .reset      (reset),
      .wr_valid_i (wr_valid[k]),
      .wr_word_i  (wr_word[k]),
      .wr_keep_i  (wr_keep[k]),
      .wr_drop_i  (wr_drop[k]),
      .wr_ready_o (wr_ready[k]),
      .rd_valid_o (rd_valid[k]),
      .rd_word_o  (rd_word[k]),
      .rd_ready_i (rd_ready[k]),
      .next_i     (rd_next[k]),
      .redo_i     (rd_redo[k])
    );
  end

  lane_merge merge_i (
    .clock        (clock),
    .reset        (reset),
    .ack_i        (ack_i),
    .nack_i       (nack_i),
    .lane_valid_i (rd_valid),
    .lane_word_i  (rd_word),
    .lane_ready_o (rd_ready),
    .lane_next_o  (rd_next),
    .lane_redo_o  (rd_redo),
    .m_valid_o    (m_valid_o),
    .m_beat_o     (m_beat_o),
    .m_ready_i    (m_ready_i)
  );

endmodule

// File: rtl/pkt_pkg.sv
package pkt_pkg;

  // Lane count and the width of a lane number
  localparam int LANES     = 4;
  localparam int LANE_BITS = 2;

  // Payload byte width
  localparam int DATA_BITS = 8;

  // Entries per lane FIFO and the index width into that storage
  localparam int DEPTH     = 32;
  localparam int ADDR_BITS = 5;

  typedef logic [LANE_BITS-1:0] lane_t;
  typedef logic [DATA_BITS-1:0] data_t;

  // FIFO pointer, one extra MSB as wrap bit for full/empty
  typedef logic [ADDR_BITS:0] ptr_t;

  // Beat as held in a lane FIFO
  typedef struct packed {
    logic  last;
    data_t data;
  } word_t;

  // Beat on the input stream, lane is only looked at on the first beat
  typedef struct packed {
    lane_t lane;
    logic  keep;
    logic  last;
    data_t data;
  } in_beat_t;

  // Beat on the output stream, tagged with its source lane
  typedef struct packed {
    lane_t lane;
    logic  last;
    data_t data;
  } out_beat_t;

  // Merge FSM
  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT_ACK,
    REWIND
  } merge_state_t;

endpackage

// File: run.sh
#!/bin/sh
# Compile RTL and testbench with Verilator, then run from the project root
cd "$(dirname "$0")" &&
  verilator --binary --timing -Wno-fatal --top-module packet_switch_tb \
    -f build.f -o packet_switch_sim &&
  ./obj_dir/packet_switch_sim ||
  { echo "simulation run failed"; exit 1; }
